// File: src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;
        typedef logic [31:0] instr_t;
        typedef logic [4:0]  mode_t;
        typedef logic [3:0]  arch_reg_t;
        typedef logic [4:0]  phy_reg_t;
        typedef logic [31:0] word_t;

        typedef struct packed {
                logic   t;      // Thumb state.
                mode_t  mode;
        } cpsr_t;

        localparam int    PHY_REGS   = 27;
        localparam int    CP_LATENCY = 3;

        localparam mode_t MODE_USR = 5'b10000;
        localparam mode_t MODE_FIQ = 5'b10001;
        localparam mode_t MODE_IRQ = 5'b10010;
        localparam mode_t MODE_SVC = 5'b10011;
        localparam mode_t MODE_SYS = 5'b11111;

        // Match with casez.
        localparam instr_t PAT_MRC     = 32'b????_1110_???1_????_????_????_???1_????;
        localparam instr_t PAT_MCR     = 32'b????_1110_???0_????_????_????_???1_????;
        localparam instr_t PAT_LDC     = 32'b????_110?_???1_????_????_????_????_????;
        localparam instr_t PAT_STC     = 32'b????_110?_???0_????_????_????_????_????;
        localparam instr_t PAT_CDP     = 32'b????_1110_????_????_????_????_???0_????;
        localparam instr_t PAT_MOV_IMM = 32'b????_0011_101?_????_????_????_????_????;

        function automatic phy_reg_t bank_translate(input arch_reg_t r, input mode_t m);
                phy_reg_t p;
                p = {1'b0, r};
                case (m)
                MODE_FIQ:
                        if (r >= 4'd8 && r <= 4'd14)
                                p = 5'd16 + {2'b00, r[2:0]};    // r8..r14 to 16..22.
                MODE_IRQ:
                        if (r == 4'd13 || r == 4'd14)
                                p = 5'd22 + {3'b000, r[1:0]};   // 23, 24.
                MODE_SVC:
                        if (r == 4'd13 || r == 4'd14)
                                p = 5'd24 + {3'b000, r[1:0]};   // 25, 26.
                MODE_USR, MODE_SYS:
                        p = {1'b0, r};
                default:
                        p = {1'b0, r};  // Other modes see the user bank.
                endcase
                return p;
        endfunction
endpackage

`default_nettype wire

// File: src/copro_if_pkg.sv
`default_nettype none

package copro_if_pkg;
        // Payload of the input and retire streams.
        typedef struct packed {
                cpu_isa_pkg::instr_t    instr;
                cpu_isa_pkg::cpsr_t     cpsr;
        } instr_beat_t;

        // Whole instruction plus the translated core register.
        typedef struct packed {
                cpu_isa_pkg::instr_t    instr;
                cpu_isa_pkg::phy_reg_t  core_reg;
        } copro_req_t;

        typedef enum logic [1:0] {
                PD_IDLE,
                PD_DRAIN,
                PD_BUSY
        } predec_state_t;
endpackage

`default_nettype wire

// File: src/core_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module core_regfile
(
        input  wire                             i_clk,
        input  wire                             i_reset,

        input  wire                             i_a_we,
        input  wire cpu_isa_pkg::phy_reg_t      i_a_waddr,
        input  wire cpu_isa_pkg::word_t         i_a_wdata,

        input  wire                             i_b_we,
        input  wire cpu_isa_pkg::phy_reg_t      i_b_waddr,
        input  wire cpu_isa_pkg::word_t         i_b_wdata,

        input  wire cpu_isa_pkg::phy_reg_t      i_r0_addr,
        output cpu_isa_pkg::word_t              o_r0_data,
        input  wire cpu_isa_pkg::phy_reg_t      i_r1_addr,
        output cpu_isa_pkg::word_t              o_r1_data
);
        import cpu_isa_pkg::*;

        word_t  regs [PHY_REGS];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < PHY_REGS; i++)
                                regs[i] <= '0;
                end
                else
                begin
                        if (i_a_we && i_a_waddr < phy_reg_t'(PHY_REGS))
                                regs[i_a_waddr] <= i_a_wdata;
                        if (i_b_we && i_b_waddr < phy_reg_t'(PHY_REGS))
                                regs[i_b_waddr] <= i_b_wdata;   // Port B wins a tie.
                end
        end

        // Unmapped indices read as zero.
        assign o_r0_data = (i_r0_addr < phy_reg_t'(PHY_REGS)) ? regs[i_r0_addr] : '0;
        assign o_r1_data = (i_r1_addr < phy_reg_t'(PHY_REGS)) ? regs[i_r1_addr] : '0;
endmodule

`default_nettype wire

// File: src/issue_pipe.sv
`default_nettype none
`timescale 1ns/1ps

module issue_pipe
(
        input  wire                             i_clk,
        input  wire                             i_reset,

        input  wire                             i_valid,
        output logic                            o_ready,
        input  wire copro_if_pkg::instr_beat_t  i_beat,

        output logic                            o_ret_valid,
        input  wire                             i_ret_ready,
        output copro_if_pkg::instr_beat_t       o_ret_beat,

        output logic                            o_busy,

        output logic                            o_rf_we,
        output cpu_isa_pkg::phy_reg_t           o_rf_waddr,
        output cpu_isa_pkg::word_t              o_rf_wdata
);
        import cpu_isa_pkg::*;
        import copro_if_pkg::*;

        logic           s1_valid;
        logic           s2_valid;
        logic           s3_valid;
        instr_beat_t    s1_beat;
        instr_beat_t    s2_beat;
        instr_beat_t    s3_beat;
        logic           adv1;
        logic           adv2;
        logic           adv3;
        logic           s2_mov;

        // A stage moves when it is empty or the one after it moves.
        assign adv3 = !s3_valid || i_ret_ready;
        assign adv2 = !s2_valid || adv3;
        assign adv1 = !s1_valid || adv2;

        assign o_ready     = adv1;
        assign o_busy      = s1_valid || s2_valid || s3_valid;
        assign o_ret_valid = s3_valid;
        assign o_ret_beat  = s3_beat;

        always_comb
        begin
                casez (s2_beat.instr)
                PAT_MOV_IMM:
                        s2_mov = 1'b1;
                default:
                        s2_mov = 1'b0;
                endcase
        end

        // Execute as the beat leaves stage 2.
        assign o_rf_we    = s2_valid && adv3 && s2_mov;
        assign o_rf_waddr = bank_translate(s2_beat.instr[15:12], s2_beat.cpsr.mode);
        assign o_rf_wdata = {24'd0, s2_beat.instr[7:0]};

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        s1_valid <= 1'b0;
                        s2_valid <= 1'b0;
                        s3_valid <= 1'b0;
                end
                else
                begin
                        if (adv3)
                                s3_valid <= s2_valid;
                        if (adv2)
                                s2_valid <= s1_valid;
                        if (adv1)
                                s1_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (adv3)
                        s3_beat <= s2_beat;
                if (adv2)
                        s2_beat <= s1_beat;
                if (adv1)
                        s1_beat <= i_beat;
        end
endmodule

`default_nettype wire

// File: src/copro_unit.sv
`default_nettype none
`timescale 1ns/1ps

module copro_unit
(
        input  wire                             i_clk,
        input  wire                             i_reset,

        input  wire                             i_req_valid,
        input  wire copro_if_pkg::copro_req_t   i_req,
        output logic                            o_done,

        output cpu_isa_pkg::phy_reg_t           o_rf_raddr,
        input  wire cpu_isa_pkg::word_t         i_rf_rdata,
        output logic                            o_rf_we,
        output cpu_isa_pkg::phy_reg_t           o_rf_waddr,
        output cpu_isa_pkg::word_t              o_rf_wdata
);
        import cpu_isa_pkg::*;
        import copro_if_pkg::*;

        typedef logic [$clog2(CP_LATENCY + 1)-1:0] lat_cnt_t;

        copro_req_t     req_q;
        logic           active;
        lat_cnt_t       cnt;
        word_t          cr [16];
        logic           is_mcr;
        logic           is_mrc;
        logic           is_cdp;
        logic [3:0]     crn;
        logic [3:0]     crm;
        logic [3:0]     crd;
        word_t          cdp_result;

        assign crn = req_q.instr[19:16];
        assign crd = req_q.instr[15:12];
        assign crm = req_q.instr[3:0];

        always_comb
        begin
                is_mcr = 1'b0;
                is_mrc = 1'b0;
                is_cdp = 1'b0;
                casez (req_q.instr)
                PAT_MRC:
                        is_mrc = 1'b1;
                PAT_MCR:
                        is_mcr = 1'b1;
                PAT_CDP:
                        is_cdp = 1'b1;
                default:
                        is_cdp = 1'b0;  // LDC and STC just complete.
                endcase
        end

        // Opcode1 zero adds, anything else xors.
        assign cdp_result = (req_q.instr[23:20] == 4'd0) ? cr[crn] + cr[crm]
                                                         : cr[crn] ^ cr[crm];

        // Request cycle plus CP_LATENCY.
        assign o_done = active && (cnt == lat_cnt_t'(CP_LATENCY));

        assign o_rf_raddr = req_q.core_reg;
        assign o_rf_we    = o_done && is_mrc;
        assign o_rf_waddr = req_q.core_reg;
        assign o_rf_wdata = cr[crn];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        active <= 1'b0;
                        cnt    <= '0;
                end
                else if (i_req_valid)
                begin
                        active <= 1'b1;
                        cnt    <= lat_cnt_t'(1);
                end
                else if (o_done)
                        active <= 1'b0;
                else if (active)
                        cnt <= cnt + lat_cnt_t'(1);
        end

        always_ff @(posedge i_clk)
        begin
                if (i_req_valid)
                        req_q <= i_req;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < 16; i++)
                                cr[i] <= '0;
                end
                else if (o_done)
                begin
                        if (is_mcr)
                                cr[crn] <= i_rf_rdata;
                        else if (is_cdp)
                                cr[crd] <= cdp_result;
                end
        end
endmodule

`default_nettype wire

// File: src/copro_predecode.sv
`default_nettype none
`timescale 1ns/1ps

module copro_predecode
(
        input  wire                             i_clk,
        input  wire                             i_reset,

        input  wire                             i_in_valid,
        output logic                            o_in_ready,
        input  wire copro_if_pkg::instr_beat_t  i_in_beat,

        output logic                            o_pipe_valid,
        input  wire                             i_pipe_ready,
        output copro_if_pkg::instr_beat_t       o_pipe_beat,
        input  wire                             i_pipe_busy,

        output logic                            o_cp_valid,
        output copro_if_pkg::copro_req_t        o_cp_req,
        input  wire                             i_cp_done
);
        import cpu_isa_pkg::*;
        import copro_if_pkg::*;

        predec_state_t  state;
        logic           is_cp;
        logic           cp_hit;
        logic           drain_done;
        phy_reg_t       cp_reg;

        always_comb
        begin
                casez (i_in_beat.instr)
                PAT_MRC, PAT_MCR, PAT_LDC, PAT_STC, PAT_CDP:
                        is_cp = !i_in_beat.cpsr.t;      // ARM state only.
                default:
                        is_cp = 1'b0;
                endcase
        end

        assign cp_hit     = i_in_valid && is_cp;
        assign drain_done = (state == PD_DRAIN) && !i_pipe_busy;

        // MCR and MRC name Rd, the rest name Rn.
        always_comb
        begin
                if (i_in_beat.instr[27:24] == 4'b1110 && i_in_beat.instr[4])
                        cp_reg = bank_translate(i_in_beat.instr[15:12], i_in_beat.cpsr.mode);
                else
                        cp_reg = bank_translate(i_in_beat.instr[19:16], i_in_beat.cpsr.mode);
        end

        assign o_pipe_beat  = i_in_beat;
        assign o_pipe_valid = (state == PD_IDLE) && i_in_valid && !is_cp;

        always_comb
        begin
                case (state)
                PD_IDLE:
                        o_in_ready = i_pipe_ready && !cp_hit;
                PD_BUSY:
                        o_in_ready = i_cp_done; // Beat is consumed, never retired.
                default:
                        o_in_ready = 1'b0;
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state      <= PD_IDLE;
                        o_cp_valid <= 1'b0;
                end
                else
                begin
                        o_cp_valid <= 1'b0;
                        case (state)
                        PD_IDLE:
                                if (cp_hit)
                                        state <= PD_DRAIN;
                        PD_DRAIN:
                                if (drain_done)
                                begin
                                        state      <= PD_BUSY;
                                        o_cp_valid <= 1'b1;     // Single cycle pulse.
                                end
                        PD_BUSY:
                                if (i_cp_done)
                                        state <= PD_IDLE;
                        default:
                                state <= PD_IDLE;
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (drain_done)
                begin
                        o_cp_req.instr    <= i_in_beat.instr;
                        o_cp_req.core_reg <= cp_reg;
                end
        end
endmodule

`default_nettype wire

// File: src/copro_subsys_top.sv
`default_nettype none
`timescale 1ns/1ps

module copro_subsys_top
(
        input  wire                             i_clk,
        input  wire                             i_reset,

        input  wire                             i_in_valid,
        output logic                            o_in_ready,
        input  wire copro_if_pkg::instr_beat_t  i_in_beat,

        output logic                            o_ret_valid,
        input  wire                             i_ret_ready,
        output copro_if_pkg::instr_beat_t       o_ret_beat,

        input  wire cpu_isa_pkg::phy_reg_t      i_dbg_addr,
        output cpu_isa_pkg::word_t              o_dbg_data
);
        import cpu_isa_pkg::*;
        import copro_if_pkg::*;

        logic           pipe_valid;
        logic           pipe_ready;
        instr_beat_t    pipe_beat;
        logic           pipe_busy;
        logic           cp_valid;
        copro_req_t     cp_req;
        logic           cp_done;
        logic           pipe_we;
        phy_reg_t       pipe_waddr;
        word_t          pipe_wdata;
        phy_reg_t       cp_raddr;
        word_t          cp_rdata;
        logic           cp_we;
        phy_reg_t       cp_waddr;
        word_t          cp_wdata;

        copro_predecode u_predecode
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_in_valid     (i_in_valid),
                .o_in_ready     (o_in_ready),
                .i_in_beat      (i_in_beat),
                .o_pipe_valid   (pipe_valid),
                .i_pipe_ready   (pipe_ready),
                .o_pipe_beat    (pipe_beat),
                .i_pipe_busy    (pipe_busy),
                .o_cp_valid     (cp_valid),
                .o_cp_req       (cp_req),
                .i_cp_done      (cp_done)
        );

        issue_pipe u_pipe
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_valid        (pipe_valid),
                .o_ready        (pipe_ready),
                .i_beat         (pipe_beat),
                .o_ret_valid    (o_ret_valid),
                .i_ret_ready    (i_ret_ready),
                .o_ret_beat     (o_ret_beat),
                .o_busy         (pipe_busy),
                .o_rf_we        (pipe_we),
                .o_rf_waddr     (pipe_waddr),
                .o_rf_wdata     (pipe_wdata)
        );

        // Read port 0 serves the debug port.
        core_regfile u_regfile
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_a_we         (pipe_we),
                .i_a_waddr      (pipe_waddr),
                .i_a_wdata      (pipe_wdata),
                .i_b_we         (cp_we),
                .i_b_waddr      (cp_waddr),
                .i_b_wdata      (cp_wdata),
                .i_r0_addr      (i_dbg_addr),
                .o_r0_data      (o_dbg_data),
                .i_r1_addr      (cp_raddr),
                .o_r1_data      (cp_rdata)
        );

        copro_unit u_copro
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_req_valid    (cp_valid),
                .i_req          (cp_req),
                .o_done         (cp_done),
                .o_rf_raddr     (cp_raddr),
                .i_rf_rdata     (cp_rdata),
                .o_rf_we        (cp_we),
                .o_rf_waddr     (cp_waddr),
                .o_rf_wdata     (cp_wdata)
        );
endmodule

`default_nettype wire

// File: tb/tb_copro_subsys.sv
`default_nettype none
`timescale 1ns/1ps

module tb_copro_subsys;
        import cpu_isa_pkg::*;
        import copro_if_pkg::*;

        localparam string GOLDEN_FILE = "tb/copro_golden.txt";
        localparam int    LINE_CYCLES = 400;

        logic           i_clk = 1'b0;
        logic           i_reset;
        logic           i_in_valid;
        logic           o_in_ready;
        instr_beat_t    i_in_beat;
        logic           o_ret_valid;
        logic           i_ret_ready = 1'b0;
        instr_beat_t    o_ret_beat;
        phy_reg_t       i_dbg_addr;
        word_t          o_dbg_data;

        logic [31:0]    rng = 32'h1b14;
        instr_beat_t    exp_q [$];
        string          lines [$];
        int             n_lines = 0;
        int             errors = 0;
        int             checks = 0;
        int             test_errors = 0;
        int             cur_test = 0;
        int             tests_run = 0;

        copro_subsys_top u_copro_subsys_top
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_in_valid     (i_in_valid),
                .o_in_ready     (o_in_ready),
                .i_in_beat      (i_in_beat),
                .o_ret_valid    (o_ret_valid),
                .i_ret_ready    (i_ret_ready),
                .o_ret_beat     (o_ret_beat),
                .i_dbg_addr     (i_dbg_addr),
                .o_dbg_data     (o_dbg_data)
        );

        always #50 i_clk = ~i_clk;

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // Retire port stalls about one cycle in four.
        always @(posedge i_clk)
        begin
                #5;
                rng = lcg_next(rng);
                i_ret_ready = (rng[17:16] != 2'b00);
        end

        function automatic instr_beat_t make_beat(input logic [31:0] t, input logic [31:0] mode,
                                                  input logic [31:0] instr);
                instr_beat_t b;
                b.instr     = instr;
                b.cpsr.t    = t[0];
                b.cpsr.mode = mode[4:0];
                return b;
        endfunction

        task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                                   input string what);
                checks++;
                if (got !== expected)
                begin
                        $display("ERROR @ %0t ns: %s is %0h, expected %0h",
                                 $time, what, got, expected);
                        errors++;
                        test_errors++;
                end
        endtask

        task automatic next_cycle();
                @(posedge i_clk);
                #5;
        endtask

        // Retire transfers are decided mid cycle, where all inputs are settled.
        task automatic watch_retire();
                instr_beat_t expected;
                forever
                begin
                        @(negedge i_clk);
                        if (!i_reset && o_ret_valid && i_ret_ready)
                        begin
                                if (exp_q.size() == 0)
                                begin
                                        $display("Unexpected retire of %h at %0t ns",
                                                 o_ret_beat.instr, $time);
                                        errors++;
                                        test_errors++;
                                end
                                else
                                begin
                                        expected = exp_q.pop_front();
                                        check_value(64'(o_ret_beat), 64'(expected),
                                                    "retired beat");
                                end
                        end
                end
        endtask

        task automatic send_beat(input instr_beat_t b);
                bit done;
                done       = 1'b0;
                i_in_valid = 1'b1;
                i_in_beat  = b;
                while (!done)
                begin
                        @(negedge i_clk);
                        done = o_in_ready;      // Transfer at the coming edge.
                        next_cycle();
                end
                i_in_valid = 1'b0;
        endtask

        task automatic wait_drain();
                while (exp_q.size() != 0)
                        next_cycle();
        endtask

        task automatic check_reg(input phy_reg_t idx, input word_t value);
                wait_drain();
                i_dbg_addr = idx;
                @(negedge i_clk);
                check_value(64'(o_dbg_data), 64'(value), $sformatf("r[%0d]", idx));
                next_cycle();
        endtask

        task automatic finish_test();
                if (cur_test != 0)
                begin
                        wait_drain();
                        tests_run++;
                        $display("Test %0d finished with %0d errors", cur_test, test_errors);
                end
        endtask

        task automatic run_line(input string line);
                byte            cmd;
                string          args;
                logic [31:0]    a;
                logic [31:0]    b;
                logic [31:0]    c;
                cmd  = line.getc(0);
                args = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
                a    = '0;
                b    = '0;
                c    = '0;
                void'($sscanf(args, "%h %h %h", a, b, c));
                case (cmd)
                "T":
                begin
                        finish_test();
                        cur_test    = int'(a);
                        test_errors = 0;
                end
                "R":
                        exp_q.push_back(make_beat(a, b, c));
                "S":
                        send_beat(make_beat(a, b, c));
                "C":
                        check_reg(phy_reg_t'(a), b);
                default:
                        ;       // Comment or blank line.
                endcase
        endtask

        // Run limit scales with the length of the golden file.
        initial
        begin
                wait (n_lines != 0);
                repeat (n_lines * LINE_CYCLES) @(posedge i_clk);
                $display("Watchdog expired after %0d cycles, the run did not complete",
                         n_lines * LINE_CYCLES);
                $display("=== FAIL ===");
                $finish;
        end

        initial
        begin
                int     fd;
                string  line;
                i_reset    = 1'b1;
                i_in_valid = 1'b0;
                i_in_beat  = '0;
                i_dbg_addr = '0;
                fd = $fopen(GOLDEN_FILE, "r");
                if (fd == 0)
                begin
                        $display("Could not open the golden file %s", GOLDEN_FILE);
                        $display("=== FAIL ===");
                        $finish;
                end
                else
                begin
                        while ($fgets(line, fd) != 0)
                                lines.push_back(line);
                        $fclose(fd);
                        n_lines = lines.size() + 1;
                        repeat (8) @(posedge i_clk);
                        #5;
                        i_reset = 1'b0;
                        fork
                                watch_retire();
                        join_none
                        foreach (lines[i])
                                run_line(lines[i]);
                        finish_test();
                        repeat (10) next_cycle();       // Catch stray retires.
                        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
                        if (errors == 0)
                                $display("=== PASS ===");
                        else
                                $display("=== FAIL ===");
                        $finish;
                end
        end
endmodule

`default_nettype wire

// File: tb/copro_golden.txt
# T <test>   S|R <t bit> <mode> <instr>   C <phys reg> <value>, all hex
# R records come before the S beats whose retire they predict
T 1
R 0 10 e0810002
R 0 10 e0432001
R 0 10 e1a00000
R 0 10 e2811001
S 0 10 e0810002
S 0 10 e0432001
S 0 10 e1a00000
S 0 10 e2811001
T 2
R 0 10 e3a09033
R 0 11 e3a09044
S 0 10 e3a09033
S 0 11 e3a09044
C 09 00000033
C 11 00000044
T 3
S 0 10 ee029f10
S 0 10 ee123f10
C 03 00000033
C 09 00000033
T 4
R 0 10 e3a0400f
S 0 10 e3a0400f
S 0 10 ee054f10
S 0 10 ee026f05
S 0 10 ee127f05
S 0 10 ee165f10
S 0 10 ee176f10
C 05 00000042
C 06 0000003c
T 5
R 0 10 e3a0a077
R 0 10 e3a0b088
S 0 10 e3a0a077
S 0 10 e3a0b088
S 0 10 ee08af10
S 0 10 ee09bf10
S 0 10 ee18cf10
S 0 10 ee197f10
S 0 10 ed901f00
S 0 10 ed801f00
C 0c 00000077
C 07 00000088
C 00 00000000
C 01 00000000
T 6
R 1 10 ee123f10
S 1 10 ee123f10
C 03 00000033

// File: verilog.f
src/cpu_isa_pkg.sv
src/copro_if_pkg.sv
src/core_regfile.sv
src/issue_pipe.sv
src/copro_unit.sv
src/copro_predecode.sv
src/copro_subsys_top.sv
tb/tb_copro_subsys.sv

// File: Makefile
TOP := tb_copro_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
